//--- logic/la_pkg.sv
package la_pkg;

    // Datapath and register-number widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Multi-cycle sequence, one instruction at a time
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } cpu_state_e;

    // ALU operation, binary coded
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,   // Also address and link computation
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11   // Passes src2
    } alu_op_e;

    // Control transfer kind
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_B    = 3'd1,
        BR_BL   = 3'd2,
        BR_BEQ  = 3'd3,
        BR_BNE  = 3'd4,
        BR_JIRL = 3'd5
    } br_kind_e;

endpackage

//--- logic/la_decode.sv
`timescale 1ns/1ps

module la_decode (
    input  logic [la_pkg::XLEN-1:0]       inst,
    output la_pkg::alu_op_e               alu_op,
    output la_pkg::br_kind_e              br_kind,
    output logic                          src1_is_pc,
    output logic                          src2_is_imm,
    output logic                          gr_we,
    output logic                          mem_we,
    output logic                          res_from_mem,
    output logic [la_pkg::XLEN-1:0]       imm,
    output logic [la_pkg::XLEN-1:0]       br_offs,
    output logic [la_pkg::REG_ADDR_W-1:0] rf_raddr1,
    output logic [la_pkg::REG_ADDR_W-1:0] rf_raddr2,
    output logic [la_pkg::REG_ADDR_W-1:0] dest
);
    import la_pkg::*;

    logic [5:0]            op_31_26;
    logic [3:0]            op_25_22;
    logic [1:0]            op_21_20;
    logic [4:0]            op_19_15;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [XLEN-1:0]       ui5;
    logic [XLEN-1:0]       si12;
    logic [XLEN-1:0]       si16;
    logic [XLEN-1:0]       si20;
    logic [XLEN-1:0]       si26;
    logic                  src_reg_is_rd;
    logic                  dst_is_r1;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign ui5  = {27'b0, inst[14:10]};
    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign si20 = {inst[24:5], 12'b0};
    assign si16 = {{14{inst[25]}}, inst[25:10], 2'b0};    // Branch offsets are word scaled
    assign si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    always_comb begin
        // Unknown encodings fall through as a no-op
        alu_op        = ALU_ADD;
        br_kind       = BR_NONE;
        src1_is_pc    = 1'b0;
        src2_is_imm   = 1'b0;
        gr_we         = 1'b0;
        mem_we        = 1'b0;
        res_from_mem  = 1'b0;
        src_reg_is_rd = 1'b0;
        dst_is_r1     = 1'b0;
        imm           = si12;
        br_offs       = si16;
        case (op_31_26)
            6'h00: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    gr_we = 1'b1;
                    case (op_19_15)
                        5'h00:   alu_op = ALU_ADD;
                        5'h02:   alu_op = ALU_SUB;
                        5'h04:   alu_op = ALU_SLT;
                        5'h05:   alu_op = ALU_SLTU;
                        5'h08:   alu_op = ALU_NOR;
                        5'h09:   alu_op = ALU_AND;
                        5'h0a:   alu_op = ALU_OR;
                        5'h0b:   alu_op = ALU_XOR;
                        default: gr_we  = 1'b0;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    gr_we       = 1'b1;
                    src2_is_imm = 1'b1;
                    imm         = ui5;
                    case (op_19_15)
                        5'h01:   alu_op = ALU_SLL;
                        5'h09:   alu_op = ALU_SRL;
                        5'h11:   alu_op = ALU_SRA;
                        default: gr_we  = 1'b0;
                    endcase
                end else if (op_25_22 == 4'ha) begin    // addi.w
                    gr_we       = 1'b1;
                    src2_is_imm = 1'b1;
                end
            end
            6'h05: begin
                if (!inst[25]) begin    // lu12i.w
                    alu_op      = ALU_LUI;
                    gr_we       = 1'b1;
                    src2_is_imm = 1'b1;
                    imm         = si20;
                end
            end
            6'h0a: begin
                if (op_25_22 == 4'h2) begin
                    gr_we        = 1'b1;
                    src2_is_imm  = 1'b1;
                    res_from_mem = 1'b1;
                end else if (op_25_22 == 4'h6) begin
                    src2_is_imm   = 1'b1;
                    mem_we        = 1'b1;
                    src_reg_is_rd = 1'b1;    // Store data comes from rd
                end
            end
            6'h13: begin
                br_kind     = BR_JIRL;
                gr_we       = 1'b1;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                imm         = 32'd4;    // Link value pc+4
            end
            6'h14: begin
                br_kind = BR_B;
                br_offs = si26;
            end
            6'h15: begin
                br_kind     = BR_BL;
                gr_we       = 1'b1;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                dst_is_r1   = 1'b1;
                imm         = 32'd4;
                br_offs     = si26;
            end
            6'h16: begin
                br_kind       = BR_BEQ;
                src_reg_is_rd = 1'b1;
            end
            6'h17: begin
                br_kind       = BR_BNE;
                src_reg_is_rd = 1'b1;
            end
            default: ;
        endcase
    end

    assign rf_raddr1 = rj;
    assign rf_raddr2 = src_reg_is_rd ? rd : rk;
    assign dest      = dst_is_r1 ? 5'd1 : rd;

endmodule

//--- logic/la_execute.sv
`timescale 1ns/1ps

module la_execute (
    input  la_pkg::alu_op_e         alu_op,
    input  la_pkg::br_kind_e        br_kind,
    input  logic                    src1_is_pc,
    input  logic                    src2_is_imm,
    input  logic [la_pkg::XLEN-1:0] pc,
    input  logic [la_pkg::XLEN-1:0] imm,
    input  logic [la_pkg::XLEN-1:0] br_offs,
    input  logic [la_pkg::XLEN-1:0] rf_rdata1,
    input  logic [la_pkg::XLEN-1:0] rf_rdata2,
    output logic [la_pkg::XLEN-1:0] alu_result,
    output logic [la_pkg::XLEN-1:0] br_target,
    output logic                    br_taken
);
    import la_pkg::*;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [4:0]      shamt;
    logic            rj_eq_rd;

    assign src1  = src1_is_pc ? pc : rf_rdata1;
    assign src2  = src2_is_imm ? imm : rf_rdata2;
    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = src1 + src2;
            ALU_SUB:  alu_result = src1 - src2;
            ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_result = {31'b0, src1 < src2};
            ALU_AND:  alu_result = src1 & src2;
            ALU_NOR:  alu_result = ~(src1 | src2);
            ALU_OR:   alu_result = src1 | src2;
            ALU_XOR:  alu_result = src1 ^ src2;
            ALU_SLL:  alu_result = src1 << shamt;
            ALU_SRL:  alu_result = src1 >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(src1) >>> shamt);
            ALU_LUI:  alu_result = src2;
            default:  alu_result = '0;
        endcase
    end

    // rf_rdata2 holds rd for beq/bne
    assign rj_eq_rd = (rf_rdata1 == rf_rdata2);

    always_comb begin
        case (br_kind)
            BR_B, BR_BL, BR_JIRL: br_taken = 1'b1;
            BR_BEQ:               br_taken = rj_eq_rd;
            BR_BNE:               br_taken = !rj_eq_rd;
            default:              br_taken = 1'b0;
        endcase
    end

    assign br_target = (br_kind == BR_JIRL) ? rf_rdata1 + br_offs : pc + br_offs;

endmodule

//--- logic/la_result.sv
`timescale 1ns/1ps

module la_result #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                          clk,
    input  logic                          reset,
    input  la_pkg::cpu_state_e            state,
    input  logic [la_pkg::XLEN-1:0]       pc,
    input  logic [la_pkg::XLEN-1:0]       alu_result,
    input  logic [la_pkg::XLEN-1:0]       data_sram_rdata,
    input  logic                          gr_we,
    input  logic                          res_from_mem,
    input  logic [la_pkg::REG_ADDR_W-1:0] rf_raddr1,
    input  logic [la_pkg::REG_ADDR_W-1:0] rf_raddr2,
    input  logic [la_pkg::REG_ADDR_W-1:0] dest,
    output logic [la_pkg::XLEN-1:0]       rf_rdata1,
    output logic [la_pkg::XLEN-1:0]       rf_rdata2,
    output logic [la_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [la_pkg::XLEN-1:0]       debug_wb_rf_wdata,
    output logic                          debug_wb_rf_we,
    output logic [la_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum
);
    import la_pkg::*;

    logic [XLEN-1:0] rf [2**REG_ADDR_W];
    logic [XLEN-1:0] retire_pc;
    logic [XLEN-1:0] alu_q;
    logic [XLEN-1:0] mem_q;
    logic [XLEN-1:0] wb_data;
    logic            rf_we;

    // pc moves on before writeback, so keep the retiring one here
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_pc <= RESET_PC;
        end else if (state == DECODE) begin
            retire_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXECUTE) alu_q <= alu_result;
        if (state == MEMORY) mem_q <= data_sram_rdata;    // Load data
    end

    assign wb_data = res_from_mem ? mem_q : alu_q;
    assign rf_we   = (state == WRITEBACK) && gr_we;

    always_ff @(posedge clk) begin
        if (rf_we) rf[dest] <= wb_data;
    end

    // r0 is hardwired to zero on read
    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : rf[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : rf[rf_raddr2];

    assign debug_wb_pc       = retire_pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

//--- logic/la_control.sv
`timescale 1ns/1ps

module la_control #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  la_pkg::br_kind_e        br_kind,
    input  logic                    br_taken,
    input  logic                    mem_we,
    input  logic                    res_from_mem,
    input  logic [la_pkg::XLEN-1:0] br_target,
    input  logic [la_pkg::XLEN-1:0] alu_result,
    input  logic [la_pkg::XLEN-1:0] rf_rdata2,
    input  logic [la_pkg::XLEN-1:0] inst_sram_rdata,
    output la_pkg::cpu_state_e      state,
    output logic [la_pkg::XLEN-1:0] pc,
    output logic [la_pkg::XLEN-1:0] inst,
    output logic [la_pkg::XLEN-1:0] inst_sram_addr,
    output logic [la_pkg::XLEN-1:0] data_sram_addr,
    output logic [la_pkg::XLEN-1:0] data_sram_wdata,
    output logic                    data_sram_we
);
    import la_pkg::*;

    cpu_state_e      next_state;
    logic            is_cond_br;    // Resolved in DECODE
    logic            is_mem;
    logic            pc_update;
    logic [XLEN-1:0] next_pc;

    assign is_cond_br = (br_kind == BR_B) || (br_kind == BR_BEQ) || (br_kind == BR_BNE);
    assign is_mem     = mem_we || res_from_mem;

    always_comb begin
        case (state)
            FETCH:     next_state = DECODE;
            DECODE:    next_state = is_cond_br ? FETCH : EXECUTE;
            EXECUTE:   next_state = is_mem ? MEMORY : WRITEBACK;
            MEMORY:    next_state = res_from_mem ? WRITEBACK : FETCH;
            WRITEBACK: next_state = FETCH;
            default:   next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) state <= FETCH;
        else       state <= next_state;
    end

    assign pc_update = (state == DECODE && is_cond_br) || (state == EXECUTE);
    assign next_pc   = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_update) begin
            pc <= next_pc;
        end
    end

    // Instruction SRAM answers in the same cycle
    assign inst_sram_addr = pc;

    always_ff @(posedge clk) begin
        if (state == FETCH) inst <= inst_sram_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_sram_we <= 1'b0;
        end else if (state == EXECUTE && is_mem) begin
            data_sram_we <= mem_we;
        end else if (state == MEMORY) begin
            data_sram_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXECUTE && is_mem) begin
            data_sram_addr  <= alu_result;
            data_sram_wdata <= rf_rdata2;
        end
    end

endmodule

//--- logic/la_core.sv
`timescale 1ns/1ps

module la_core #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import la_pkg::*;

    cpu_state_e            state;
    alu_op_e               alu_op;
    br_kind_e              br_kind;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       br_offs;
    logic [XLEN-1:0]       br_target;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [REG_ADDR_W-1:0] dest;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  gr_we;
    logic                  mem_we;
    logic                  res_from_mem;
    logic                  br_taken;

    la_control #(.RESET_PC(RESET_PC)) u_control (
        .clk, .reset, .br_kind, .br_taken, .mem_we, .res_from_mem,
        .br_target, .alu_result, .rf_rdata2, .inst_sram_rdata,
        .state, .pc, .inst, .inst_sram_addr,
        .data_sram_addr, .data_sram_wdata, .data_sram_we
    );

    la_decode u_decode (
        .inst, .alu_op, .br_kind, .src1_is_pc, .src2_is_imm, .gr_we,
        .mem_we, .res_from_mem, .imm, .br_offs, .rf_raddr1, .rf_raddr2, .dest
    );

    la_execute u_execute (
        .alu_op, .br_kind, .src1_is_pc, .src2_is_imm, .pc, .imm, .br_offs,
        .rf_rdata1, .rf_rdata2, .alu_result, .br_target, .br_taken
    );

    la_result #(.RESET_PC(RESET_PC)) u_result (
        .clk, .reset, .state, .pc, .alu_result, .data_sram_rdata,
        .gr_we, .res_from_mem, .rf_raddr1, .rf_raddr2, .dest,
        .rf_rdata1, .rf_rdata2, .debug_wb_pc, .debug_wb_rf_wdata,
        .debug_wb_rf_we, .debug_wb_rf_wnum
    );

endmodule

//--- verif/la_tb_mem.sv
`timescale 1ns/1ps

module la_tb_mem #(
    parameter logic [31:0] ROM_BASE  = 32'h1c00_0000,
    parameter int          ROM_WORDS = 256
) (
    input  logic        clk,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    input  logic        data_we,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata
);
    logic [31:0] rom [ROM_WORDS];    // Loaded by the testbench before reset falls
    logic [31:0] ram [256];
    logic [31:0] rom_off;

    // Word index into the ROM, anything outside reads as zero
    assign rom_off    = (inst_addr - ROM_BASE) >> 2;
    assign inst_rdata = (rom_off < ROM_WORDS) ? rom[rom_off] : 32'h0;

    // Data RAM reads in the same cycle as the address
    assign data_rdata = ram[data_addr[9:2]];

    initial begin
        for (int i = 0; i < 256; i++) begin
            ram[i] = {22'b0, i[7:0], 2'b00} ^ 32'h5a5a_5a5a;
        end
    end

    always @(posedge clk) begin
        if (data_we) ram[data_addr[9:2]] <= data_wdata;
    end

endmodule

//--- verif/la_core_tb.sv
`timescale 1ns/1ps

module la_core_tb;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam int          N_TESTS  = 6;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // Program image and the test each word belongs to
    logic [31:0] prog [256];
    int          prog_test [256];
    int          n_prog;
    int          cur_test;
    int          halt_idx;

    // Expected retire list and store list from the golden model
    logic [31:0] exp_pc [128];
    logic [31:0] exp_num [128];
    logic [31:0] exp_data [128];
    int          exp_cyc [128];
    int          exp_test [128];
    int          n_exp;
    int          ret_idx;
    logic [31:0] st_addr [16];
    logic [31:0] st_data [16];
    int          st_cyc [16];
    int          st_test [16];
    int          n_st;
    int          st_idx;

    logic [31:0] grf [32];
    logic [31:0] gmem [int];

    int    checks;
    int    errors;
    int    test_err [N_TESTS];
    int    last_of_test [N_TESTS];
    string test_name [N_TESTS];
    int    cyc;

    la_core #(.RESET_PC(RESET_PC)) u_la_core (
        .clk, .reset, .inst_sram_addr, .inst_sram_rdata, .data_sram_we,
        .data_sram_addr, .data_sram_wdata, .data_sram_rdata, .debug_wb_pc,
        .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    la_tb_mem #(.ROM_BASE(RESET_PC)) u_mem (
        .clk,
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] r3_word(input logic [16:0] op, input int rd, rj, rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] shift_word(input logic [16:0] op, input int rd, rj, sa);
        return {op, sa[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input int rd, rj, si);
        return {op, si[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] lu12i_word(input int rd, input int si);
        return {7'h0a, si[19:0], rd[4:0]};
    endfunction

    // Offsets are in words, relative to the branch
    function automatic logic [31:0] branch16_word(input logic [5:0] op, input int rd, rj, offs);
        return {op, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] branch26_word(input logic [5:0] op, input int offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[n_prog]      = w;
        prog_test[n_prog] = cur_test;
        n_prog++;
    endtask

    task automatic build_program;
        cur_test = 0;    // First fetch and first writeback
        emit(lu12i_word(4, ($urandom & 32'h7ffff) | 32'h1));    // Positive
        cur_test = 1;
        emit(ri12_word(10'h00a, 4, 4, $urandom));
        emit(lu12i_word(5, $urandom & 32'hfffff));
        emit(ri12_word(10'h00a, 5, 5, $urandom));
        emit(lu12i_word(6, ($urandom & 32'hfffff) | 32'h80000));    // Negative
        emit(ri12_word(10'h00a, 6, 6, $urandom));
        emit(r3_word(17'h20, 7, 4, 5));
        emit(r3_word(17'h22, 8, 4, 5));
        emit(r3_word(17'h24, 9, 4, 6));
        emit(r3_word(17'h24, 10, 6, 4));
        emit(r3_word(17'h25, 11, 4, 6));
        emit(r3_word(17'h25, 12, 6, 4));
        emit(r3_word(17'h28, 13, 4, 5));
        emit(r3_word(17'h29, 14, 4, 5));
        emit(r3_word(17'h2a, 15, 4, 6));
        emit(r3_word(17'h2b, 16, 5, 6));
        emit(shift_word(17'h81, 17, 6, $urandom | 32'h1));    // Nonzero shift amounts
        emit(shift_word(17'h89, 18, 6, $urandom | 32'h1));
        emit(shift_word(17'h91, 19, 6, $urandom | 32'h1));
        emit(ri12_word(10'h00a, 0, 4, $urandom));    // Write to r0
        emit(r3_word(17'h20, 20, 0, 5));
        cur_test = 2;
        emit(ri12_word(10'h00a, 21, 0, 32'h100));
        emit(ri12_word(10'h0a6, 4, 21, 8));
        emit(ri12_word(10'h0a2, 22, 21, 8));
        emit(r3_word(17'h20, 23, 22, 0));
        cur_test = 3;
        emit(branch16_word(6'h16, 4, 4, 2));
        emit(ri12_word(10'h00a, 24, 0, 1));
        emit(branch16_word(6'h16, 5, 4, 2));
        emit(ri12_word(10'h00a, 24, 0, 2));
        emit(branch16_word(6'h17, 5, 4, 2));
        emit(ri12_word(10'h00a, 25, 0, 4));
        emit(branch16_word(6'h17, 4, 4, 2));
        emit(ri12_word(10'h00a, 25, 0, 3));
        emit(branch26_word(6'h14, 2));
        emit(ri12_word(10'h00a, 26, 0, 5));
        emit(ri12_word(10'h00a, 26, 0, 6));
        cur_test = 4;
        emit(branch26_word(6'h15, 2));
        emit(ri12_word(10'h00a, 27, 0, 7));
        emit(branch16_word(6'h13, 28, 1, 4));    // Lands three words past itself
        emit(ri12_word(10'h00a, 29, 0, 8));
        emit(ri12_word(10'h00a, 29, 0, 9));
        emit(ri12_word(10'h00a, 30, 28, 0));
        cur_test = 5;
        emit(ri12_word(10'h00a, 2, 0, 9));
        emit(ri12_word(10'h0a2, 3, 21, 8));
        emit(ri12_word(10'h00a, 2, 3, 1));
        halt_idx = n_prog;
        emit(branch26_word(6'h14, 0));    // Spin here
    endtask

    // Instruction set model with the cycle counts of the multi-cycle core
    task automatic run_golden;
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rdv;
        logic [31:0] val;
        logic [31:0] nxt;
        logic [31:0] s12;
        logic [31:0] o16;
        logic [31:0] o26;
        logic [31:0] addr;
        logic        wr;
        int          idx;
        int          n;
        int          t;
        int          dst;
        pc = RESET_PC;
        t  = 0;
        for (int i = 0; i < 32; i++) grf[i] = '0;
        for (int step = 0; step < 200; step++) begin
            idx = (pc - RESET_PC) >> 2;
            if (idx == halt_idx) break;
            w   = prog[idx];
            a   = grf[w[9:5]];
            b   = grf[w[14:10]];
            rdv = grf[w[4:0]];
            s12 = {{20{w[21]}}, w[21:10]};
            o16 = {{14{w[25]}}, w[25:10], 2'b00};
            o26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            dst = w[4:0];
            wr  = 1'b1;
            n   = 4;
            val = '0;
            nxt = pc + 4;
            case (w[31:26])
                6'h00: begin
                    if (w[31:22] == 10'h00a) begin
                        val = a + s12;
                    end else begin
                        case (w[31:15])
                            17'h20: val = a + b;
                            17'h22: val = a - b;
                            17'h24: val = ($signed(a) < $signed(b)) ? 1 : 0;
                            17'h25: val = (a < b) ? 1 : 0;
                            17'h28: val = ~(a | b);
                            17'h29: val = a & b;
                            17'h2a: val = a | b;
                            17'h2b: val = a ^ b;
                            17'h81: val = a << w[14:10];
                            17'h89: val = a >> w[14:10];
                            17'h91: val = $signed(a) >>> w[14:10];
                            default: wr = 1'b0;
                        endcase
                    end
                end
                6'h05: val = {w[24:5], 12'b0};
                6'h0a: begin
                    addr = a + s12;
                    if (w[25:22] == 4'h2) begin
                        n   = 5;
                        val = gmem.exists(addr) ? gmem[addr]
                                                : (addr & 32'h3fc) ^ 32'h5a5a_5a5a;
                    end else begin
                        wr            = 1'b0;
                        gmem[addr]    = rdv;
                        st_addr[n_st] = addr;
                        st_data[n_st] = rdv;
                        st_cyc[n_st]  = t + 3;
                        st_test[n_st] = prog_test[idx];
                        n_st++;
                    end
                end
                6'h13: begin
                    val = pc + 4;
                    nxt = a + o16;
                end
                6'h14: begin
                    wr  = 1'b0;
                    n   = 2;
                    nxt = pc + o26;
                end
                6'h15: begin
                    val = pc + 4;
                    dst = 1;
                    nxt = pc + o26;
                end
                6'h16, 6'h17: begin
                    wr = 1'b0;
                    n  = 2;
                    if ((a == rdv) == (w[31:26] == 6'h16)) nxt = pc + o16;
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                exp_pc[n_exp]   = pc;
                exp_num[n_exp]  = dst;
                exp_data[n_exp] = val;
                exp_cyc[n_exp]  = t + n - 1;
                exp_test[n_exp] = prog_test[idx];
                n_exp++;
                grf[dst] = val;
                grf[0]   = '0;
            end
            t  = t + n;
            pc = nxt;
        end
    endtask

    task automatic compare(input int tid, input string name, input logic [31:0] exp_v, got);
        checks++;
        assert (got === exp_v) else begin
            $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp_v, got);
            errors++;
            test_err[tid]++;
        end
    endtask

    task automatic check_retire;
        int k;
        if (ret_idx >= n_exp) begin
            $display("Unexpected register write at %0t from pc %h", $time, debug_wb_pc);
            errors++;
            return;
        end
        k = exp_test[ret_idx];
        compare(k, "debug_wb_pc", exp_pc[ret_idx], debug_wb_pc);
        compare(k, "debug_wb_rf_wnum", exp_num[ret_idx], {27'b0, debug_wb_rf_wnum});
        compare(k, "debug_wb_rf_wdata", exp_data[ret_idx], debug_wb_rf_wdata);
        compare(k, "retire_cycle", exp_cyc[ret_idx], cyc);
        if (ret_idx == last_of_test[k]) begin
            $display("test %0d %-7s %s errors=%0d", k, test_name[k],
                     (test_err[k] == 0) ? "ok" : "FAILED", test_err[k]);
        end
        ret_idx++;
    endtask

    task automatic check_store;
        int k;
        if (st_idx >= n_st) begin
            $display("Unexpected data write at %0t to address %h", $time, data_sram_addr);
            errors++;
            return;
        end
        k = st_test[st_idx];
        compare(k, "data_sram_addr", st_addr[st_idx], data_sram_addr);
        compare(k, "data_sram_wdata", st_data[st_idx], data_sram_wdata);
        compare(k, "store_cycle", st_cyc[st_idx], cyc);
        st_idx++;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            cyc = 0;
        end else begin
            if (cyc == 0) compare(0, "inst_sram_addr", RESET_PC, inst_sram_addr);
            if (debug_wb_rf_we) check_retire();
            if (data_sram_we) check_store();
            cyc++;
        end
    end

    initial begin
        int seed;
        int idle;
        int last;
        reset    = 1'b1;
        clk      = 1'b0;
        seed     = $urandom(52);
        n_prog   = 0;
        n_exp    = 0;
        n_st     = 0;
        ret_idx  = 0;
        st_idx   = 0;
        checks   = 0;
        errors   = 0;
        cyc      = 0;
        test_name = '{"reset", "alu", "memory", "branch", "link", "timing"};
        for (int i = 0; i < N_TESTS; i++) begin
            test_err[i]     = 0;
            last_of_test[i] = -1;
        end
        for (int i = 0; i < 256; i++) prog[i] = '0;
        build_program();
        run_golden();
        for (int i = 0; i < n_exp; i++) last_of_test[exp_test[i]] = i;
        for (int i = 0; i < 256; i++) u_mem.rom[i] = prog[i];

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        idle = 0;
        last = 0;
        while (ret_idx < n_exp && idle < 40) begin
            @(posedge clk);
            if (ret_idx != last) begin
                last = ret_idx;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (ret_idx < n_exp) begin
            $display("Timeout: core stopped retiring after %0d of %0d writes", ret_idx, n_exp);
            errors++;
        end else begin
            repeat (20) @(posedge clk);    // Nothing may retire from the spin loop
            if (st_idx != n_st) begin
                $display("Only %0d of %0d stores reached the data SRAM", st_idx, n_st);
                errors++;
            end
        end

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
logic/la_pkg.sv
logic/la_decode.sv
logic/la_execute.sv
logic/la_result.sv
logic/la_control.sv
logic/la_core.sv
verif/la_tb_mem.sv
verif/la_core_tb.sv

//--- Bender.yml
package:
  name: la_core

sources:
  - logic/la_pkg.sv
  - logic/la_decode.sv
  - logic/la_execute.sv
  - logic/la_result.sv
  - logic/la_control.sv
  - logic/la_core.sv
  - target: test
    files:
      - verif/la_tb_mem.sv
      - verif/la_core_tb.sv
